// ==== include/fpu_rnd_params.svh ====
// widths, limits and special-value patterns of the fp rounding back end
`ifndef FPU_RND_PARAMS_SVH
`define FPU_RND_PARAMS_SVH

//////////////////////////////
// field widths
//////////////////////////////

// unrounded fraction: carry, hidden, 23 fraction bits, r, two sticky bits
`define FPU_FRACT_IN_W  28
`define FPU_FRACT_OUT_W 24   // significand incl. hidden bit
`define FPU_EXP_W       10   // extended exponent, room for overflow
`define FPU_SHIFT_W     5    // align shift amount

//////////////////////////////
// limits and patterns
//////////////////////////////

`define FPU_EXP_MAX     254  // largest finite biased exponent

// 31-bit magnitudes, sign is prepended at packing
`define FPU_QNAN        31'h7fc0_0000
`define FPU_SNAN        31'h7fbf_ffff  // substitute for invalid ops
`define FPU_INF         31'h7f80_0000

`endif

// ==== design/fpu_status_pkg.sv ====
// status types: rounding mode and exception flags

package fpu_status_pkg;

  //////////////////////////////
  // rounding mode
  //////////////////////////////

  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,  // ties to even
    RM_TO_ZERO = 2'b01,  // truncate
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rmode_e;

  //////////////////////////////
  // exception flags
  //////////////////////////////

  typedef struct packed {
    logic ovf;  // overflow
    logic unf;  // underflow
    logic snf;  // snan produced
    logic qnf;  // qnan produced
    logic zf;   // zero result
    logic ixf;  // inexact
    logic ivf;  // invalid
    logic inf;  // infinite result
  } fpu_flags_t;

endpackage

// ==== design/fpu_num_pkg.sv ====
// number formats: source bundles, stage payloads, output word
`include "fpu_rnd_params.svh"

package fpu_num_pkg;

  // add/sub unit output
  typedef struct packed {
    logic                        rdy;
    logic                        sign;
    logic                        sub_0;     // true subtraction, zero result
    logic [`FPU_SHIFT_W-1:0]     shl;
    logic [`FPU_EXP_W-1:0]       exp_shl;   // exponent if left shifted
    logic [`FPU_EXP_W-1:0]       exp_sh0;   // exponent if not shifted
    logic [`FPU_FRACT_IN_W-1:0]  fract;
    logic                        inv;
    logic                        inf;
    logic                        snan;
    logic                        qnan;
    logic                        anan_sign; // sign for nan output
  } add_src_t;

  // multiplier output
  typedef struct packed {
    logic                        rdy;
    logic                        sign;
    logic [`FPU_SHIFT_W-1:0]     shr;
    logic [`FPU_EXP_W-1:0]       exp_shr;
    logic                        shl;       // at most one position
    logic [`FPU_EXP_W-1:0]       exp_shl;
    logic [`FPU_EXP_W-1:0]       exp_sh0;
    logic [`FPU_FRACT_IN_W-1:0]  fract;
    logic                        inv;
    logic                        inf;
    logic                        snan;
    logic                        qnan;
    logic                        anan_sign;
  } mul_src_t;

  // stage 1 payload, guard bit is fract[0]
  typedef struct packed {
    logic                         sign;
    logic [`FPU_EXP_W-1:0]        exp;
    logic [`FPU_FRACT_OUT_W+1:0]  fract;
    logic                         r;
    logic                         sticky;
    logic                         inv;
    logic                         inf;
    logic                         snan;
    logic                         qnan;
    logic                         anan_sign;
  } align_t;

  typedef struct packed {
    logic                         sign;
    logic [`FPU_EXP_W-1:0]        exp;
    logic [`FPU_FRACT_OUT_W-1:0]  fract24;
    logic                         lost;    // inexact
  } round_t;

  typedef struct packed {
    logic [31:0]                  word;
    fpu_status_pkg::fpu_flags_t   flags;
  } result_t;

endpackage

// ==== design/fpu_pipe_reg.sv ====
// pipeline register with valid, loads on advance, cleared by flush
`timescale 1ns/1ps

module fpu_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic flush_i,
  input  logic adv_i,
  input  logic valid_i,
  input  T     data_i,
  output logic valid_o,
  output T     data_o
);

  // flush wins over advance
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;
      data_o  <= '0;
    end else if (adv_i) begin
      valid_o <= valid_i;
      data_o  <= data_i;
    end
    // adv_i low: hold
  end

endmodule

// ==== design/fpu_align.sv ====
// stage 1: source select, fraction align, sticky, exponent, register
`timescale 1ns/1ps
`include "fpu_rnd_params.svh"

module fpu_align (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush_i,
  input  logic                   adv_i,
  input  fpu_num_pkg::add_src_t  add_i,
  input  fpu_num_pkg::mul_src_t  mul_i,
  input  fpu_status_pkg::rmode_e rmode_i,
  output logic                   valid_o,
  output fpu_num_pkg::align_t    align_o
);
  import fpu_num_pkg::*;
  import fpu_status_pkg::*;

  localparam int SH_W = `FPU_FRACT_IN_W + 1; // spare msb for left shift

  logic                       add_sign;
  logic                       carry;
  logic [`FPU_FRACT_IN_W-1:0] fract;
  logic [`FPU_SHIFT_W-1:0]    shr_src, shr, shl;
  logic [`FPU_EXP_W-1:0]      exp_shr, exp_shl, exp_sh0;
  logic [SH_W-1:0]            fract_ext, fract_sh, lo_mask;
  logic [`FPU_SHIFT_W:0]      cut;
  logic                       sticky_r, sticky_l;
  align_t                     nxt;

  // zero from true subtraction: sign depends on mode
  assign add_sign = add_i.sub_0 ? (rmode_i == RM_TO_INFM) : add_i.sign;

  //////////////////////////////
  // source mux, rdy masked
  //////////////////////////////

  assign {nxt.sign, nxt.inv, nxt.inf, nxt.snan, nxt.qnan, nxt.anan_sign} =
    ({6{add_i.rdy}} & {add_sign, add_i.inv, add_i.inf, add_i.snan, add_i.qnan,
                       add_i.anan_sign}) |
    ({6{mul_i.rdy}} & {mul_i.sign, mul_i.inv, mul_i.inf, mul_i.snan, mul_i.qnan,
                       mul_i.anan_sign});

  assign fract = ({`FPU_FRACT_IN_W{add_i.rdy}} & add_i.fract) |
                 ({`FPU_FRACT_IN_W{mul_i.rdy}} & mul_i.fract);

  // add/sub never shifts right
  assign {shr_src, shl} =
    ({(2*`FPU_SHIFT_W){add_i.rdy}} & {{`FPU_SHIFT_W{1'b0}}, add_i.shl}) |
    ({(2*`FPU_SHIFT_W){mul_i.rdy}} & {mul_i.shr, {(`FPU_SHIFT_W-1){1'b0}}, mul_i.shl});

  assign {exp_shr, exp_shl, exp_sh0} =
    ({(3*`FPU_EXP_W){add_i.rdy}} & {add_i.exp_sh0, add_i.exp_shl, add_i.exp_sh0}) |
    ({(3*`FPU_EXP_W){mul_i.rdy}} & {mul_i.exp_shr, mul_i.exp_shl, mul_i.exp_sh0});

  // carry out of add/mul -> one step right
  assign carry = fract[`FPU_FRACT_IN_W-1];
  assign shr   = (|shr_src) ? shr_src : {{(`FPU_SHIFT_W-1){1'b0}}, carry};

  //////////////////////////////
  // align and sticky
  //////////////////////////////

  assign fract_ext = {1'b0, fract};
  assign fract_sh  = (|shr) ? (fract_ext >> shr) : (fract_ext << shl);

  // bits below r after a right shift: original [shr+1:0]
  assign cut      = {1'b0, shr} + (`FPU_SHIFT_W+1)'(2);
  assign lo_mask  = ~({SH_W{1'b1}} << cut);
  assign sticky_r = |(fract_ext & lo_mask);
  assign sticky_l = |fract_sh[1:0];          // left shift drops nothing low

  assign nxt.fract  = fract_sh[SH_W-1:3];
  assign nxt.r      = fract_sh[2];
  assign nxt.sticky = (|shr) ? sticky_r : sticky_l;

  // exponent follows the chosen shift
  assign nxt.exp = (|shr_src) ? exp_shr :
                   (~(|shl))  ? (exp_sh0 + `FPU_EXP_W'(carry)) :
                                exp_shl;

  fpu_pipe_reg #(.T(align_t)) i_s1_reg (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv_i),
    .valid_i (add_i.rdy | mul_i.rdy),
    .data_i  (nxt),
    .valid_o (valid_o),
    .data_o  (align_o)
  );

endmodule

// ==== design/fpu_round.sv ====
// stage 2: round decision, increment, renormalize
`timescale 1ns/1ps
`include "fpu_rnd_params.svh"

module fpu_round (
  input  fpu_status_pkg::rmode_e rmode_i,
  input  fpu_num_pkg::align_t    align_i,
  output fpu_num_pkg::round_t    round_o
);
  import fpu_status_pkg::*;

  localparam int AL_W = `FPU_FRACT_OUT_W + 2;

  logic            g;
  logic            r;
  logic            s;
  logic            lost;
  logic            rnd_up;
  logic [AL_W-1:0] sum;
  logic            renorm;

  assign g    = align_i.fract[0];  // lsb kept
  assign r    = align_i.r;
  assign s    = align_i.sticky;
  assign lost = r | s;

  //////////////////////////////
  // round direction
  //////////////////////////////

  // mode is a live level, not staged
  always_comb begin
    case (rmode_i)
      RM_NEAREST: rnd_up = (r & s) | (g & r & ~s); // tie -> even
      RM_TO_ZERO: rnd_up = 1'b0;
      RM_TO_INFP: rnd_up = ~align_i.sign & lost;
      RM_TO_INFM: rnd_up = align_i.sign & lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  //////////////////////////////
  // increment and renormalize
  //////////////////////////////

  assign sum    = align_i.fract + AL_W'(rnd_up);
  assign renorm = sum[`FPU_FRACT_OUT_W];  // 1.11..1 + 1 -> 10.00..0

  assign round_o.sign    = align_i.sign;
  assign round_o.exp     = align_i.exp + `FPU_EXP_W'(renorm);
  assign round_o.fract24 = renorm ? sum[`FPU_FRACT_OUT_W:1]
                                  : sum[`FPU_FRACT_OUT_W-1:0];
  assign round_o.lost    = lost;

endmodule

// ==== design/fpu_pack.sv ====
// result packing with special-case priority, exception flags
`timescale 1ns/1ps
`include "fpu_rnd_params.svh"

module fpu_pack (
  input  fpu_num_pkg::align_t  align_i,
  input  fpu_num_pkg::round_t  round_i,
  output fpu_num_pkg::result_t result_o
);

  localparam logic [`FPU_EXP_W-1:0] EXP_MAX = `FPU_EXP_MAX;

  logic is_nan;
  logic is_big;
  logic denorm;

  assign is_nan = align_i.snan | align_i.qnan;
  assign is_big = align_i.inf | (round_i.exp > EXP_MAX);
  assign denorm = ~round_i.fract24[`FPU_FRACT_OUT_W-1];  // hidden bit clear

  // first match wins
  always_comb begin
    result_o = '0;
    if (is_nan) begin
      result_o.word      = {align_i.anan_sign, `FPU_QNAN};
      result_o.flags.qnf = align_i.qnan;
      result_o.flags.ivf = align_i.snan;
    end else if (align_i.inv) begin
      // invalid op, e.g. inf - inf
      result_o.word      = {round_i.sign, `FPU_SNAN};
      result_o.flags.ivf = 1'b1;
      result_o.flags.snf = 1'b1;
    end else if (is_big) begin
      result_o.word      = {round_i.sign, `FPU_INF};
      result_o.flags.inf = 1'b1;
      result_o.flags.ovf = ~align_i.inf;                // real overflow only
      result_o.flags.ixf = round_i.lost | ~align_i.inf;
    end else if (denorm) begin
      result_o.word      = {round_i.sign, 8'd0,
                            round_i.fract24[`FPU_FRACT_OUT_W-2:0]};
      result_o.flags.unf = round_i.lost;
      result_o.flags.zf  = ~(|round_i.fract24);
      result_o.flags.ixf = round_i.lost;
    end else begin
      result_o.word      = {round_i.sign, round_i.exp[7:0],
                            round_i.fract24[`FPU_FRACT_OUT_W-2:0]};
      result_o.flags.ixf = round_i.lost;
    end
  end

endmodule

// ==== design/fpu_rnd_top.sv ====
// rounding back end top: align stage, round/pack, output register
`timescale 1ns/1ps

module fpu_rnd_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush_i,
  input  logic                       adv_i,
  input  fpu_status_pkg::rmode_e     rmode_i,
  input  fpu_num_pkg::add_src_t      add_i,
  input  fpu_num_pkg::mul_src_t      mul_i,
  output logic [31:0]                result_o,
  output logic                       arith_valid_o,
  output fpu_status_pkg::fpu_flags_t fpcsr_o
);
  import fpu_num_pkg::*;

  logic    s1_valid;
  align_t  s1_align;
  round_t  s2_round;   // comb
  result_t s2_result;  // comb
  result_t out_q;

  fpu_align i_align (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv_i),
    .add_i   (add_i),
    .mul_i   (mul_i),
    .rmode_i (rmode_i),
    .valid_o (s1_valid),
    .align_o (s1_align)
  );

  fpu_round i_round (
    .rmode_i (rmode_i),
    .align_i (s1_align),
    .round_o (s2_round)
  );

  fpu_pack i_pack (
    .align_i  (s1_align),
    .round_i  (s2_round),
    .result_o (s2_result)
  );

  ////////////////////////////// output register
  fpu_pipe_reg #(.T(result_t)) i_out_reg (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv_i),
    .valid_i (s1_valid),
    .data_i  (s2_result),
    .valid_o (arith_valid_o),
    .data_o  (out_q)
  );

  assign result_o = out_q.word;
  assign fpcsr_o  = out_q.flags;

endmodule

// ==== verification/tb_clk_gen.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #50 clk_o = ~clk_o;  // 100 ns period

endmodule

// ==== verification/fpu_rnd_assert.sv ====
// bound checker with reference model of both stages and output assertions
`timescale 1ns/1ps
`include "fpu_rnd_params.svh"

module fpu_rnd_assert (
  input logic                       clk,
  input logic                       rst,
  input logic                       flush_i,
  input logic                       adv_i,
  input fpu_status_pkg::rmode_e     rmode_i,
  input fpu_num_pkg::add_src_t      add_i,
  input fpu_num_pkg::mul_src_t      mul_i,
  input logic [31:0]                result_o,
  input logic                       arith_valid_o,
  input fpu_status_pkg::fpu_flags_t fpcsr_o
);
  import fpu_num_pkg::*;
  import fpu_status_pkg::*;

  // accepted source with sign already resolved
  typedef struct packed {
    logic                       sign;
    logic [`FPU_EXP_W-1:0]      exp;
    logic [`FPU_FRACT_IN_W-1:0] fract;
    logic                       inv;
    logic                       inf;
    logic                       snan;
    logic                       qnan;
    logic                       anan_sign;
  } src_m_t;

  src_m_t  s1_nxt;
  src_m_t  s1_m;        // model stage 1
  logic    s1_v;
  result_t out_m;       // model output register
  logic    out_v;
  logic    fail_flag = 1'b0;  // stays set after any failed assertion

  ////////////////////////////// expected result
  function automatic result_t predict(src_m_t s, rmode_e rm);
    result_t                     res;
    logic [`FPU_FRACT_OUT_W-1:0] m;
    logic [`FPU_FRACT_OUT_W:0]   sum;
    logic [`FPU_EXP_W-1:0]       e;
    logic                        r;
    logic                        st;
    logic                        up;
    res = '0;
    e   = s.exp + `FPU_EXP_W'(s.fract[27]);
    if (s.fract[27]) begin    // carry out so one step right
      m  = s.fract[27:4];
      r  = s.fract[3];
      st = |s.fract[2:0];
    end else begin
      m  = s.fract[26:3];
      r  = s.fract[2];
      st = |s.fract[1:0];
    end
    case (rm)
      RM_NEAREST: up = r && (st || m[0]);  // ties go to even
      RM_TO_INFP: up = !s.sign && (r || st);
      RM_TO_INFM: up = s.sign && (r || st);
      default:    up = 1'b0;
    endcase
    sum = {1'b0, m} + up;
    if (sum[24]) begin        // rounded past all ones
      m = sum[24:1];
      e = e + 1'b1;
    end else begin
      m = sum[23:0];
    end
    if (s.snan || s.qnan) begin
      res.word      = {s.anan_sign, `FPU_QNAN};
      res.flags.qnf = s.qnan;
      res.flags.ivf = s.snan;
    end else if (s.inv) begin
      res.word      = {s.sign, `FPU_SNAN};
      res.flags.ivf = 1'b1;
      res.flags.snf = 1'b1;
    end else if (s.inf || e > `FPU_EXP_MAX) begin
      res.word      = {s.sign, `FPU_INF};
      res.flags.inf = 1'b1;
      res.flags.ovf = !s.inf;
      res.flags.ixf = r || st || !s.inf;
    end else if (!m[23]) begin
      res.word      = {s.sign, 8'd0, m[22:0]};  // denormal or zero
      res.flags.unf = r || st;
      res.flags.zf  = (m == '0);
      res.flags.ixf = r || st;
    end else begin
      res.word      = {s.sign, e[7:0], m[22:0]};
      res.flags.ixf = r || st;
    end
    return res;
  endfunction

  ////////////////////////////// model pipeline
  always_comb begin
    s1_nxt = '0;
    if (add_i.rdy) begin
      s1_nxt = '{add_i.sub_0 ? (rmode_i == RM_TO_INFM) : add_i.sign, add_i.exp_sh0,
                 add_i.fract, add_i.inv, add_i.inf, add_i.snan, add_i.qnan,
                 add_i.anan_sign};
    end else if (mul_i.rdy) begin
      s1_nxt = '{mul_i.sign, mul_i.exp_sh0, mul_i.fract, mul_i.inv, mul_i.inf,
                 mul_i.snan, mul_i.qnan, mul_i.anan_sign};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      s1_v  <= 1'b0;
      out_v <= 1'b0;
    end else if (adv_i) begin
      s1_v  <= add_i.rdy || mul_i.rdy;
      s1_m  <= s1_nxt;
      out_v <= s1_v;
      out_m <= predict(s1_m, rmode_i);  // mode is live at stage 2
    end
  end

  ////////////////////////////// assertions
  a_valid: assert property (@(posedge clk) disable iff (rst) arith_valid_o == out_v)
    else begin
      $error("Error %0t arith_valid_o expected %b actual %b", $time,
             $sampled(out_v), $sampled(arith_valid_o));
      fail_flag = 1'b1;
    end

  a_word: assert property (@(posedge clk) disable iff (rst)
                           arith_valid_o |-> result_o == out_m.word)
    else begin
      $error("Error %0t result_o expected %h actual %h", $time,
             $sampled(out_m.word), $sampled(result_o));
      fail_flag = 1'b1;
    end

  a_flags: assert property (@(posedge clk) disable iff (rst)
                            arith_valid_o |-> fpcsr_o == out_m.flags)
    else begin
      $error("Error %0t fpcsr_o expected %b actual %b", $time,
             $sampled(out_m.flags), $sampled(fpcsr_o));
      fail_flag = 1'b1;
    end

  // everything zero one edge after reset or flush
  a_clear: assert property (@(posedge clk) (rst || flush_i) |=>
                            !arith_valid_o && result_o == '0 && fpcsr_o == '0)
    else begin
      $error("Error %0t arith_valid_o result_o fpcsr_o expected 0 0 0 actual %b %h %b",
             $time, $sampled(arith_valid_o), $sampled(result_o), $sampled(fpcsr_o));
      fail_flag = 1'b1;
    end

  a_hold: assert property (@(posedge clk) disable iff (rst) (!adv_i && !flush_i) |=>
                           $stable(result_o) && $stable(fpcsr_o) && $stable(arith_valid_o))
    else begin
      $error("Error %0t outputs changed while adv_i was low, result_o now %h",
             $time, $sampled(result_o));
      fail_flag = 1'b1;
    end

endmodule

bind fpu_rnd_top fpu_rnd_assert i_rnd_assert (.*);

// ==== verification/tb_fpu_rnd.sv ====
// testbench top: reset, random and directed stimulus, watchdog, pass/fail
`timescale 1ns/1ps

module tb_fpu_rnd;
  import fpu_num_pkg::*;
  import fpu_status_pkg::*;

  localparam int N_ITER    = 600;
  localparam int DRAIN_MAX = 20;
  localparam int RUN_MAX   = 5000;  // watchdog, in cycles

  logic        clk;
  logic        rst;
  logic        flush;
  logic        adv;
  rmode_e      rmode;
  add_src_t    add_src;
  mul_src_t    mul_src;
  logic [31:0] result;
  logic        arith_valid;
  fpu_flags_t  fpcsr;
  logic        chk_fail;
  integer      seed;
  int          cycles = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk));

  fpu_rnd_top i_fpu_rnd_top (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush),
    .adv_i         (adv),
    .rmode_i       (rmode),
    .add_i         (add_src),
    .mul_i         (mul_src),
    .result_o      (result),
    .arith_valid_o (arith_valid),
    .fpcsr_o       (fpcsr)
  );

  assign chk_fail = i_fpu_rnd_top.i_rnd_assert.fail_flag;

  // one source for one cycle, the idle unit carries decoy fields
  task automatic drive_src(input logic use_mul, input logic sign, input logic sub_0,
                           input logic [9:0] exp, input logic [27:0] fract,
                           input logic [4:0] spec);  // inv, inf, snan, qnan, anan_sign
    add_src_t a;
    mul_src_t m;
    a = '{!use_mul, sign, sub_0, 5'd0, exp + 10'd3, exp, fract,
          spec[4], spec[3], spec[2], spec[1], spec[0]};
    m = '{use_mul, sign, 5'd0, exp - 10'd7, 1'b0, exp + 10'd3, exp, fract,
          spec[4], spec[3], spec[2], spec[1], spec[0]};
    @(posedge clk);
    add_src <= a;
    mul_src <= m;
    adv     <= 1'b1;
    flush   <= 1'b0;
    rmode   <= rmode_e'(2'($random(seed)));
  endtask

  // sources stay as they are
  task automatic drive_ctrl(input logic adv_v, input logic flush_v);
    @(posedge clk);
    adv   <= adv_v;
    flush <= flush_v;
  endtask

  // bounded wait for an empty pipeline
  task automatic wait_drain(output logic ok);
    int quiet;
    int n;
    quiet = 0;
    n     = 0;
    while (quiet < 3 && n < DRAIN_MAX) begin
      @(negedge clk);
      quiet = arith_valid ? 0 : quiet + 1;
      n++;
    end
    ok = (quiet >= 3);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [4:0]  spec;
    logic        drained;
    seed    = 35831;
    rst     = 1'b1;
    flush   = 1'b0;
    adv     = 1'b0;
    rmode   = RM_NEAREST;
    add_src = '0;
    mul_src = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < N_ITER; i++) begin
      rnd  = $random(seed);
      spec = (5'b00010 << rnd[29:28]) | {4'd0, rnd[30]};  // one special class
      case ({$random(seed)} % 16)
        0: drive_src(rnd[26], rnd[27], 1'b0, 10'd130, {2'b01, rnd[25:3], 3'b000}, spec);
        1: drive_src(1'b0, rnd[27], 1'b1, 10'd0, 28'd0, 5'd0);   // x - x
        2: drive_ctrl(1'b1, 1'b1);                               // flush pulse
        3: repeat (1 + rnd[1:0]) drive_ctrl(1'b0, 1'b0);         // stall
        4: drive_src(rnd[26], rnd[27], 1'b0, 10'd254, {2'b01, {23{1'b1}}, rnd[2:0]}, 5'd0);
        5: drive_src(rnd[26], rnd[27], 1'b0, 10'd1 + 10'(rnd[31:24]), {1'b1, rnd[26:0]},
                     5'd0);                                      // carry out
        default: drive_src(rnd[26], rnd[27], 1'b0, 10'd1 + 10'({$random(seed)} % 260),
                           {2'b01, rnd[25:0]}, 5'd0);
      endcase
    end
    @(posedge clk);
    add_src.rdy <= 1'b0;
    mul_src.rdy <= 1'b0;
    adv         <= 1'b1;
    flush       <= 1'b0;
    wait_drain(drained);
    if (!drained) begin
      $display("Simulation failed");
      $fatal(1, "timeout waiting for the pipeline to drain");
    end else if (chk_fail) begin
      $display("Simulation failed");
      $fatal(1, "checker assertion failed");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

  // stop at the first failed assertion, or when the run goes too long
  always @(negedge clk) begin
    cycles <= cycles + 1;
    if (chk_fail) begin
      $display("Simulation failed");
      $fatal(1, "checker assertion failed");
    end else if (cycles > RUN_MAX) begin
      $display("Simulation failed");
      $fatal(1, "watchdog timeout, stimulus did not finish");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
design/fpu_status_pkg.sv
design/fpu_num_pkg.sv
design/fpu_pipe_reg.sv
design/fpu_align.sv
design/fpu_round.sv
design/fpu_pack.sv
design/fpu_rnd_top.sv
verification/tb_clk_gen.sv
verification/fpu_rnd_assert.sv
verification/tb_fpu_rnd.sv
